/* fallTop.f */
rtl/fallPkg.sv
rtl/fallTicker.sv
rtl/deepestLane.sv
rtl/laneTable.sv
rtl/scoreKeeper.sv
rtl/fallTop.sv
tests/clockGen.sv
tests/fallTop_chk.sv
tests/fallTop_tb.sv

/* rtl/deepestLane.sv */
`timescale 1ns/1ps
`default_nettype none

module deepestLane
(
	input logic [fallPkg::laneCount-1:0] laneBusy,
	input fallPkg::rowPos [fallPkg::laneCount-1:0] laneRow,
	input fallPkg::charCode [fallPkg::laneCount-1:0] laneCode,
	output fallPkg::laneIdx deepestLaneIdx,
	output fallPkg::charCode deepestCode,
	output logic anyLane
);

	fallPkg::rowPos bestRow;

	always_comb
	begin
		anyLane = 1'b0;
		bestRow = '0;
		deepestLaneIdx = '0;
		for (int i = 0; i < fallPkg::laneCount; i++)
		begin
			// strict compare so the lowest index wins a tie
			if (laneBusy[i] && (!anyLane || laneRow[i] > bestRow))
			begin
				anyLane = 1'b1;
				bestRow = laneRow[i];
				deepestLaneIdx = fallPkg::laneIdx'(i);
			end
		end
	end

	assign deepestCode = anyLane ? laneCode[deepestLaneIdx] : '0;

endmodule

`default_nettype wire

/* rtl/fallPkg.sv */
`default_nettype none

package fallPkg;

	typedef logic [7:0] charCode; // 0 never holds a real character
	typedef logic [3:0] rowPos;
	typedef logic [2:0] laneIdx;
	typedef logic [1:0] levelIdx;
	typedef logic [3:0] bcdDigit;

	typedef enum logic [1:0] {stIdle, stPlay, stWon, stLost} gameState;

	localparam int laneCount = 8;
	localparam rowPos floorRow = 4'd12; // a character past this row is a miss
	localparam int levelCount = 3;
	localparam logic [2:0] chanceInit = 3'd3;

	// indexed by level
	localparam logic [3:0] levelTarget [levelCount] = '{4'd4, 4'd5, 4'd6};
	localparam logic [3:0] tickPeriod [levelCount] = '{4'd8, 4'd6, 4'd4}; // clocks per row

endpackage

`default_nettype wire

/* rtl/fallTicker.sv */
`timescale 1ns/1ps
`default_nettype none

module fallTicker
(
	input logic clk,
	input logic pause,
	input fallPkg::gameState state,
	input fallPkg::levelIdx level,
	input logic levelClear,
	output logic tick
);

	logic [3:0] count;

	always_ff @(posedge clk or negedge pause)
	begin
		if (!pause)
		begin
			count <= '0;
			tick <= 1'b0;
		end
		else if (state != fallPkg::stPlay || levelClear)
		begin
			count <= '0; // new level starts a fresh period
			tick <= 1'b0;
		end
		else if (count == fallPkg::tickPeriod[level] - 4'd1)
		begin
			count <= '0;
			tick <= 1'b1;
		end
		else
		begin
			count <= count + 4'd1;
			tick <= 1'b0;
		end
	end

endmodule

`default_nettype wire

/* rtl/fallTop.sv */
`timescale 1ns/1ps
`default_nettype none

module fallTop
(
	input logic clk,
	input logic pause,
	input logic start,
	input logic spawnValid,
	input fallPkg::charCode spawnCode,
	input fallPkg::laneIdx spawnLane,
	input logic keyValid,
	input fallPkg::charCode keyCode,
	output logic spawnReady,
	output logic keyReady,
	output fallPkg::charCode deepestCode,
	output logic [fallPkg::laneCount-1:0] laneBusy,
	output fallPkg::bcdDigit [2:0] scoreDigits,
	output logic [2:0] chancesLeft,
	output logic [3:0] targetLeft,
	output fallPkg::levelIdx level,
	output logic won,
	output logic lost
);

	fallPkg::gameState state;
	logic levelClear;
	logic tick;
	fallPkg::rowPos [fallPkg::laneCount-1:0] laneRow;
	fallPkg::charCode [fallPkg::laneCount-1:0] laneCode;
	fallPkg::laneIdx deepestLaneIdx;
	logic anyLane;
	logic spawnFire;
	logic hitFire;
	logic hit;
	logic miss;
	logic [1:0] missCount;
	logic placed;

	assign keyReady = state == fallPkg::stPlay;
	assign spawnReady = keyReady && targetLeft != 4'd0
		&& !(placed && targetLeft == 4'd1); // pending placement takes the last slot
	assign spawnFire = spawnValid && spawnReady;
	assign hitFire = keyValid && keyReady && anyLane && keyCode == deepestCode; // wrong keys just drop

	fallTicker fallTicker_i (
		.clk(clk), .pause(pause), .state(state), .level(level),
		.levelClear(levelClear), .tick(tick)
	);

	deepestLane deepestLane_i (
		.laneBusy(laneBusy), .laneRow(laneRow), .laneCode(laneCode),
		.deepestLaneIdx(deepestLaneIdx), .deepestCode(deepestCode), .anyLane(anyLane)
	);

	laneTable laneTable_i (
		.clk(clk), .pause(pause), .tick(tick), .levelClear(levelClear),
		.spawnFire(spawnFire), .spawnCode(spawnCode), .spawnLane(spawnLane),
		.hitFire(hitFire), .hitLane(deepestLaneIdx),
		.laneBusy(laneBusy), .laneRow(laneRow), .laneCode(laneCode),
		.hit(hit), .miss(miss), .missCount(missCount), .placed(placed)
	);

	scoreKeeper scoreKeeper_i (
		.clk(clk), .pause(pause), .start(start),
		.hit(hit), .miss(miss), .missCount(missCount), .placed(placed),
		.state(state), .level(level), .levelClear(levelClear),
		.chancesLeft(chancesLeft), .targetLeft(targetLeft),
		.scoreDigits(scoreDigits), .won(won), .lost(lost)
	);

endmodule

`default_nettype wire

/* rtl/laneTable.sv */
`timescale 1ns/1ps
`default_nettype none

module laneTable
(
	input logic clk,
	input logic pause,
	input logic tick,
	input logic levelClear,
	input logic spawnFire,
	input fallPkg::charCode spawnCode,
	input fallPkg::laneIdx spawnLane,
	input logic hitFire,
	input fallPkg::laneIdx hitLane,
	output logic [fallPkg::laneCount-1:0] laneBusy,
	output fallPkg::rowPos [fallPkg::laneCount-1:0] laneRow,
	output fallPkg::charCode [fallPkg::laneCount-1:0] laneCode,
	output logic hit,
	output logic miss,
	output logic [1:0] missCount,
	output logic placed
);

	logic [fallPkg::laneCount-1:0] nextBusy;
	fallPkg::rowPos [fallPkg::laneCount-1:0] nextRow;
	fallPkg::charCode [fallPkg::laneCount-1:0] nextCode;
	logic [3:0] missSum;
	logic doPlace;

	// removal, then fall, then spawn
	always_comb
	begin
		nextBusy = laneBusy;
		nextRow = laneRow;
		nextCode = laneCode;
		missSum = '0;
		doPlace = 1'b0;
		if (hitFire)
			nextBusy[hitLane] = 1'b0;
		if (tick)
		begin
			for (int i = 0; i < fallPkg::laneCount; i++)
			begin
				if (nextBusy[i] && laneRow[i] == fallPkg::floorRow)
				begin
					nextBusy[i] = 1'b0;
					missSum = missSum + 4'd1;
				end
				else if (nextBusy[i])
					nextRow[i] = laneRow[i] + 4'd1;
			end
		end
		if (spawnFire && !laneBusy[spawnLane]) // busy before this edge means dropped
		begin
			nextBusy[spawnLane] = 1'b1;
			nextRow[spawnLane] = '0;
			nextCode[spawnLane] = spawnCode;
			doPlace = 1'b1;
		end
	end

	always_ff @(posedge clk or negedge pause)
	begin
		if (!pause)
		begin
			laneBusy <= '0;
			hit <= 1'b0;
			miss <= 1'b0;
			missCount <= '0;
			placed <= 1'b0;
		end
		else if (levelClear)
		begin
			laneBusy <= '0; // board wiped for the next level
			hit <= 1'b0;
			miss <= 1'b0;
			missCount <= '0;
			placed <= 1'b0;
		end
		else
		begin
			laneBusy <= nextBusy;
			hit <= hitFire;
			miss <= missSum != 4'd0;
			missCount <= (missSum > 4'd3) ? 2'd3 : missSum[1:0];
			placed <= doPlace;
		end
	end

	always_ff @(posedge clk)
	begin
		laneRow <= nextRow;
		laneCode <= nextCode;
	end

endmodule

`default_nettype wire

/* rtl/scoreKeeper.sv */
`timescale 1ns/1ps
`default_nettype none

module scoreKeeper
(
	input logic clk,
	input logic pause,
	input logic start,
	input logic hit,
	input logic miss,
	input logic [1:0] missCount,
	input logic placed,
	output fallPkg::gameState state,
	output fallPkg::levelIdx level,
	output logic levelClear,
	output logic [2:0] chancesLeft,
	output logic [3:0] targetLeft,
	output fallPkg::bcdDigit [2:0] scoreDigits,
	output logic won,
	output logic lost
);

	logic [3:0] resolved; // hits plus misses in this level
	logic [3:0] resolvedNext;
	logic [2:0] missAmt;
	logic [2:0] chancesNext;
	fallPkg::bcdDigit [2:0] scoreNext;
	logic carry;
	logic levelDone;
	logic lastLevel;
	fallPkg::levelIdx nextLevel;

	always_comb
	begin
		missAmt = miss ? {1'b0, missCount} : 3'd0;
		resolvedNext = resolved + {3'b000, hit} + {1'b0, missAmt};
		chancesNext = (missAmt >= chancesLeft) ? 3'd0 : chancesLeft - missAmt;
		scoreNext = scoreDigits;
		carry = 1'b1;
		for (int d = 0; d < 3; d++)
		begin
			if (carry && scoreDigits[d] == 4'd9)
				scoreNext[d] = 4'd0; // 999 rolls over to 000
			else if (carry)
			begin
				scoreNext[d] = scoreDigits[d] + 4'd1;
				carry = 1'b0;
			end
		end
	end

	assign levelDone = resolvedNext >= fallPkg::levelTarget[level];
	assign lastLevel = level == fallPkg::levelIdx'(fallPkg::levelCount - 1);
	assign nextLevel = level + 2'd1;
	assign levelClear = state == fallPkg::stPlay && levelDone && chancesNext != 3'd0;
	assign won = state == fallPkg::stWon;
	assign lost = state == fallPkg::stLost;

	always_ff @(posedge clk or negedge pause)
	begin
		if (!pause)
		begin
			state <= fallPkg::stIdle;
			level <= '0;
			chancesLeft <= '0;
			targetLeft <= '0;
			resolved <= '0;
			scoreDigits <= '0;
		end
		else
		begin
			case (state)
				fallPkg::stIdle:
				begin
					if (start)
					begin
						state <= fallPkg::stPlay;
						level <= '0;
						chancesLeft <= fallPkg::chanceInit;
						targetLeft <= fallPkg::levelTarget[0];
						resolved <= '0;
						scoreDigits <= '0;
					end
				end
				fallPkg::stPlay:
				begin
					if (hit)
						scoreDigits <= scoreNext;
					if (placed)
						targetLeft <= targetLeft - 4'd1;
					if (chancesNext == 3'd0)
					begin
						chancesLeft <= 3'd0;
						state <= fallPkg::stLost;
					end
					else if (levelDone)
					begin
						resolved <= '0;
						if (lastLevel)
							state <= fallPkg::stWon;
						else
						begin
							level <= nextLevel;
							chancesLeft <= fallPkg::chanceInit;
							targetLeft <= fallPkg::levelTarget[nextLevel];
						end
					end
					else
					begin
						chancesLeft <= chancesNext;
						resolved <= resolvedNext;
					end
				end
				default: state <= state; // won and lost hold until reset
			endcase
		end
	end

endmodule

`default_nettype wire

/* run.sh */
#!/bin/sh
# build and run the fallTop testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
	--top-module fallTop_tb -f fallTop.f \
	--Mdir obj_dir -o fallTop_sim
if [ $? -ne 0 ]; then
	echo "build failed"
	exit 1
fi

out=$(./obj_dir/fallTop_sim)
status=$?
echo "$out"
if [ $status -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi

if echo "$out" | grep -q "^Test OK$"; then
	exit 0
fi
exit 1

/* tests/clockGen.sv */
`timescale 1ns/1ps
`default_nettype none

module clockGen
(
	input logic rearm,
	output logic clk,
	output logic pause
);

	logic [2:0] holdCount;

	initial
	begin
		clk = 1'b0;
		pause = 1'b0;
		holdCount = 3'd4;
	end

	always #10 clk = ~clk; // 20 ns period

	// pause stays low for four rising edges after power-up or a rearm
	always @(posedge clk)
	begin
		if (rearm)
		begin
			pause <= 1'b0;
			holdCount <= 3'd4;
		end
		else if (holdCount != 3'd0)
		begin
			holdCount <= holdCount - 3'd1;
			pause <= holdCount == 3'd1;
		end
	end

endmodule

`default_nettype wire

/* tests/fallTop_chk.sv */
`timescale 1ns/1ps
`default_nettype none

module fallTop_chk
(
	input logic clk,
	input logic pause,
	input fallPkg::gameState state,
	input fallPkg::levelIdx level,
	input logic levelClear,
	input logic [fallPkg::laneCount-1:0] laneBusy,
	input fallPkg::rowPos [fallPkg::laneCount-1:0] laneRow,
	input fallPkg::charCode [fallPkg::laneCount-1:0] laneCode,
	input fallPkg::laneIdx deepestLaneIdx,
	input fallPkg::charCode deepestCode,
	input logic keyValid,
	input fallPkg::charCode keyCode,
	input logic spawnFire,
	input fallPkg::laneIdx spawnLane,
	input logic placed,
	input logic hit,
	input logic miss,
	input logic [1:0] missCount,
	input fallPkg::bcdDigit [2:0] scoreDigits,
	input logic [2:0] chancesLeft,
	input logic [3:0] targetLeft,
	input logic keyReady,
	input logic spawnReady,
	input logic won,
	input logic lost
);

	int failCount = 0;

	function automatic int decimalOf(input fallPkg::bcdDigit [2:0] d);
		return int'(d[2]) * 100 + int'(d[1]) * 10 + int'(d[0]);
	endfunction

	function automatic int chancesAfter(input int have, input int lose);
		return (lose >= have) ? 0 : have - lose;
	endfunction

	// no busy lane sits lower, or level with a smaller index
	function automatic bit deepestRight(input logic [fallPkg::laneCount-1:0] busy,
		input fallPkg::rowPos [fallPkg::laneCount-1:0] rows,
		input fallPkg::charCode [fallPkg::laneCount-1:0] codes,
		input fallPkg::laneIdx idx, input fallPkg::charCode got);
		bit ok;
		if (busy == '0)
			return got == '0;
		ok = busy[idx] && got == codes[idx];
		for (int i = 0; i < fallPkg::laneCount; i++)
		begin
			if (busy[i] && (rows[i] > rows[idx]
				|| (rows[i] == rows[idx] && i < int'(idx))))
				ok = 1'b0;
		end
		return ok;
	endfunction

	logic playing;
	logic onLast;
	assign playing = state == fallPkg::stPlay;
	assign onLast = level == fallPkg::levelIdx'(fallPkg::levelCount - 1);

	idleQuiet: assert property (@(posedge clk) disable iff (!pause)
		state == fallPkg::stIdle |-> !keyReady && !spawnReady && !won && !lost
			&& laneBusy == '0 && scoreDigits == '0)
		else
		begin
			$error("outputs active while idle");
			failCount++;
		end

	deepestPick: assert property (@(posedge clk) disable iff (!pause)
		deepestRight(laneBusy, laneRow, laneCode, deepestLaneIdx, deepestCode))
		else
		begin
			$error("deepestCode is not the lowest character");
			failCount++;
		end

	keyMatch: assert property (@(posedge clk) disable iff (!pause)
		keyReady && !levelClear
			|=> hit == $past(keyValid && deepestCode != '0 && keyCode == deepestCode))
		else
		begin
			$error("key transfer and hit disagree");
			failCount++;
		end

	spawnTaken: assert property (@(posedge clk) disable iff (!pause)
		spawnFire && !laneBusy[spawnLane] && !levelClear
			|=> placed && laneBusy[$past(spawnLane)])
		else
		begin
			$error("spawn into empty lane not placed");
			failCount++;
		end

	spawnDropped: assert property (@(posedge clk) disable iff (!pause)
		spawnFire && laneBusy[spawnLane] |=> !placed)
		else
		begin
			$error("spawn into busy lane was placed");
			failCount++;
		end

	targetDown: assert property (@(posedge clk) disable iff (!pause)
		placed && playing && !levelClear |=> int'(targetLeft) == int'($past(targetLeft)) - 1)
		else
		begin
			$error("targetLeft did not drop after placement");
			failCount++;
		end

	scoreStep: assert property (@(posedge clk) disable iff (!pause)
		hit && playing |=> decimalOf(scoreDigits) == (decimalOf($past(scoreDigits)) + 1) % 1000)
		else
		begin
			$error("score not raised by one");
			failCount++;
		end

	scoreHold: assert property (@(posedge clk) disable iff (!pause)
		!hit && playing |=> scoreDigits == $past(scoreDigits))
		else
		begin
			$error("score changed without a hit");
			failCount++;
		end

	chanceHold: assert property (@(posedge clk) disable iff (!pause)
		!miss && playing && !levelClear |=> chancesLeft == $past(chancesLeft))
		else
		begin
			$error("chances changed without a miss");
			failCount++;
		end

	chanceDrop: assert property (@(posedge clk) disable iff (!pause)
		miss && playing && !levelClear
			|=> int'(chancesLeft) == chancesAfter(int'($past(chancesLeft)), int'($past(missCount))))
		else
		begin
			$error("chances not lowered by the miss count");
			failCount++;
		end

	lostHolds: assert property (@(posedge clk) disable iff (!pause)
		lost |-> !keyReady && !spawnReady && !won && chancesLeft == 3'd0 ##1 lost)
		else
		begin
			$error("lost state broken");
			failCount++;
		end

	levelUp: assert property (@(posedge clk) disable iff (!pause)
		levelClear && !onLast |=> level == $past(level) + 2'd1
			&& chancesLeft == fallPkg::chanceInit && laneBusy == '0)
		else
		begin
			$error("level advance incomplete");
			failCount++;
		end

	levelWin: assert property (@(posedge clk) disable iff (!pause)
		levelClear && onLast |=> won && !lost)
		else
		begin
			$error("last level resolved without a win");
			failCount++;
		end

	wonHolds: assert property (@(posedge clk) disable iff (!pause)
		won |-> !keyReady && !spawnReady && !lost ##1 won)
		else
		begin
			$error("won state broken");
			failCount++;
		end

endmodule

`default_nettype wire

/* tests/fallTop_tb.sv */
`timescale 1ns/1ps
`default_nettype none

module fallTop_tb;

	localparam int cycleLimit = 3000; // levels of up to 6 characters, 13 ticks of 8 cycles, two games

	logic clk;
	logic pause;
	logic rearm;
	logic start;
	logic spawnValid;
	fallPkg::charCode spawnCode;
	fallPkg::laneIdx spawnLane;
	logic keyValid;
	fallPkg::charCode keyCode;
	logic spawnReady;
	logic keyReady;
	fallPkg::charCode deepestCode;
	logic [fallPkg::laneCount-1:0] laneBusy;
	fallPkg::bcdDigit [2:0] scoreDigits;
	logic [2:0] chancesLeft;
	logic [3:0] targetLeft;
	fallPkg::levelIdx level;
	logic won;
	logic lost;

	int errorCount;
	int assertFails;
	int cycleCount;
	int unsigned seedValue;

	clockGen clockGen_i (.rearm(rearm), .clk(clk), .pause(pause));

	fallTop fallTop_i (
		.clk(clk), .pause(pause), .start(start),
		.spawnValid(spawnValid), .spawnCode(spawnCode), .spawnLane(spawnLane),
		.keyValid(keyValid), .keyCode(keyCode),
		.spawnReady(spawnReady), .keyReady(keyReady), .deepestCode(deepestCode),
		.laneBusy(laneBusy), .scoreDigits(scoreDigits), .chancesLeft(chancesLeft),
		.targetLeft(targetLeft), .level(level), .won(won), .lost(lost)
	);

	bind fallTop fallTop_chk fallTop_chk_i (
		.clk(clk), .pause(pause), .state(state), .level(level), .levelClear(levelClear),
		.laneBusy(laneBusy), .laneRow(laneRow), .laneCode(laneCode),
		.deepestLaneIdx(deepestLaneIdx), .deepestCode(deepestCode),
		.keyValid(keyValid), .keyCode(keyCode),
		.spawnFire(spawnFire), .spawnLane(spawnLane),
		.placed(placed), .hit(hit), .miss(miss), .missCount(missCount),
		.scoreDigits(scoreDigits), .chancesLeft(chancesLeft), .targetLeft(targetLeft),
		.keyReady(keyReady), .spawnReady(spawnReady), .won(won), .lost(lost)
	);

	task automatic expectTrue(input logic cond, input string msg);
		assert (cond)
		else
		begin
			errorCount++;
			$display("mismatch at %0t: %s", $time, msg);
		end
	endtask

	// random spawns, keys every other cycle, mostly right ones when pressKeys is set
	task automatic playGame(input bit pressKeys);
		bit keyPhase;
		keyPhase = 1'b0;
		@(posedge clk);
		start <= 1'b1;
		@(posedge clk);
		start <= 1'b0;
		while (!won && !lost)
		begin
			@(posedge clk);
			spawnValid <= ($urandom % 4) == 0;
			spawnLane <= fallPkg::laneIdx'($urandom);
			spawnCode <= fallPkg::charCode'($urandom_range(255, 1));
			keyValid <= keyPhase;
			if (pressKeys && ($urandom % 4) != 0)
				keyCode <= deepestCode;
			else
				keyCode <= deepestCode ^ fallPkg::charCode'($urandom_range(255, 1)); // never the deepest code
			keyPhase = !keyPhase;
		end
		spawnValid <= 1'b0;
		keyValid <= 1'b0;
	endtask

	task automatic resetAgain();
		@(posedge clk);
		rearm <= 1'b1;
		@(posedge clk);
		rearm <= 1'b0;
		@(posedge clk);
		while (!pause)
			@(posedge clk);
	endtask

	always @(posedge clk)
	begin
		cycleCount <= cycleCount + 1;
		if (cycleCount >= cycleLimit)
		begin
			$display("timeout: game did not end within %0d cycles", cycleLimit);
			$display("Test FAILED");
			$finish;
		end
	end

	initial
	begin
		errorCount = 0;
		assertFails = 0;
		cycleCount = 0;
		seedValue = $urandom(20);
		rearm = 1'b0;
		start = 1'b0;
		spawnValid = 1'b0;
		spawnCode = '0;
		spawnLane = '0;
		keyValid = 1'b0;
		keyCode = '0;
		while (pause !== 1'b1)
			@(posedge clk);
		repeat (3)
		begin
			@(posedge clk);
			expectTrue(!keyReady && !spawnReady && !won && !lost, "outputs active after reset");
			expectTrue(scoreDigits == '0 && laneBusy == '0, "score or lanes not clear");
		end

		playGame(1'b0); // no right keys, ends in a loss
		repeat (5)
		begin
			@(posedge clk);
			expectTrue(lost && !won && !keyReady && !spawnReady, "lost state not held");
		end

		resetAgain();
		@(posedge clk);
		expectTrue(!lost && scoreDigits == '0, "reset did not clear the game");
		playGame(1'b1);
		repeat (5)
		begin
			@(posedge clk);
			expectTrue(won && !lost && !keyReady && !spawnReady, "won state not held");
		end
		expectTrue(level == 2'd2, "win reached before the last level");
		expectTrue(scoreDigits != '0, "win with no score");

		assertFails = fallTop_i.fallTop_chk_i.failCount;
		$display("errors: %0d mismatches, %0d assertion failures, %0d cycles run",
			errorCount, assertFails, cycleCount);
		if (errorCount == 0 && assertFails == 0)
			$display("Test OK");
		else
			$display("Test FAILED");
		$finish;
	end

endmodule

`default_nettype wire
